// File: test/mem_stimulus.txt
# B dest keep last data | S ptr addr | M addr strb data | R addr expected_line | C (clear)
# P msg_addr msg_strb msg_data rd_addr expected_line | F flag | I idle_cycles (decimal), hex elsewhere
F 0
# Slot 3 defaults to 0300, the second beat keeps its low four bytes
B 3 ff 0 0123456789abcdef
B 3 0f 1 fedcba9876543210
R 0300 0123456789abcdef
R 0308 0000000076543210
# Slot 1 moved to 0400, its old base stays untouched
S 0 0400
B 1 ff 1 a5a5a5a5a5a5a5a5
R 0400 a5a5a5a5a5a5a5a5
R 0200 0000000000000000
# Header packet based at 0500
B 0 ff 0 dead0000beef0500
B 0 ff 0 1122334455667788
B 0 ff 1 99aabbccddeeff00
R 0500 1122334455667788
R 0508 99aabbccddeeff00
R 0510 0000000000000000
# Message lanes in both halves of line 0600
M 0600 f 11223344
M 0604 3 aabbccdd
M 0600 6 55667788
R 0600 0000ccdd11667744
# Read after a message, then a read sharing its cycle with a message
M 0700 f cafef00d
R 0700 00000000cafef00d
P 0704 c 12345678 0700 12340000cafef00d
# Slot 5 at 0ff8, second beat runs past the memory
S 4 0ff8
B 5 ff 0 0102030405060708
B 5 ff 1 0807060504030201
I 2
F 1
R 0ff8 0102030405060708
R 0000 0000000000000000
C
F 0

// File: compile.f
src/riscv_mem_pkg.sv
src/slot_addr_table.sv
src/ingress_writer.sv
src/msg_port_arbiter.sv
src/dmem_byte_lane.sv
src/riscv_mem_top.sv
test/mem_checker.sv
test/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal --Mdir obj_dir
TOP       := tb_top
FILELIST  := compile.f
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_top.sv
/* Testbench top for the data memory wrapper. Replays the command file in test/
   on the falling clock edge and leaves the comparing to mem_checker */
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import riscv_mem_pkg::*;
();

  localparam int    SLOT_COUNT      = 8;
  localparam int    DMEM_SIZE_BYTES = 4096;
  localparam addr_t SLOT_START_ADDR = 16'h0200;
  localparam addr_t SLOT_ADDR_STEP  = 16'h0080;
  localparam int    SLOT_PTR_WIDTH  = $clog2(SLOT_COUNT);
  localparam string STIM_FILE       = "test/mem_stimulus.txt";
  localparam int    RESET_CYCLES    = 5;
  localparam int    CYCLES_PER_LINE = 20;
  localparam int    CYCLE_MARGIN    = 50;

  logic                      sys_clk = 1'b0;
  logic                      sys_rst;
  logic                      in_valid;
  line_t                     in_data;
  strb_t                     in_keep;
  logic                      in_last;
  slot_id_t                  in_dest;
  logic                      slot_wr;
  logic [SLOT_PTR_WIDTH-1:0] slot_wr_ptr;
  addr_t                     slot_wr_addr;
  logic                      msg_valid;
  addr_t                     msg_addr;
  msg_strb_t                 msg_strb;
  msg_data_t                 msg_data;
  logic                      rd_req;
  addr_t                     rd_addr;
  line_t                     rd_data;
  logic                      rd_ack;
  logic                      oob_clear;
  logic                      oob_flag;

  // Requests to the checker
  logic  read_start;
  line_t read_expect;
  logic  flag_check;
  logic  flag_expect;
  logic  read_busy;
  int    data_errors;
  int    flag_errors;
  int    ack_errors;

  string stim_lines[$];
  int    stim_errors = 0;
  int    cycle_limit;
  int    cycle_count = 0;

  always #50 sys_clk = ~sys_clk;

  riscv_mem_top #(
    .SLOT_COUNT      (SLOT_COUNT),
    .DMEM_SIZE_BYTES (DMEM_SIZE_BYTES),
    .SLOT_START_ADDR (SLOT_START_ADDR),
    .SLOT_ADDR_STEP  (SLOT_ADDR_STEP)
  ) DUT (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .in_keep      (in_keep),
    .in_last      (in_last),
    .in_dest      (in_dest),
    .slot_wr      (slot_wr),
    .slot_wr_ptr  (slot_wr_ptr),
    .slot_wr_addr (slot_wr_addr),
    .msg_valid    (msg_valid),
    .msg_addr     (msg_addr),
    .msg_strb     (msg_strb),
    .msg_data     (msg_data),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .rd_ack       (rd_ack),
    .oob_clear    (oob_clear),
    .oob_flag     (oob_flag)
  );

  mem_checker u_checker (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .rd_ack      (rd_ack),
    .rd_data     (rd_data),
    .oob_flag    (oob_flag),
    .read_start  (read_start),
    .read_expect (read_expect),
    .flag_check  (flag_check),
    .flag_expect (flag_expect),
    .read_busy   (read_busy),
    .data_errors (data_errors),
    .flag_errors (flag_errors),
    .ack_errors  (ack_errors)
  );

  // Run limit grows with the length of the command file
  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: stimulus still running after %0d cycles", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Drive helpers
  //////////////////////////////////////////////////
  task automatic clear_strobes();
    in_valid   = 1'b0;
    slot_wr    = 1'b0;
    msg_valid  = 1'b0;
    rd_req     = 1'b0;
    oob_clear  = 1'b0;
    read_start = 1'b0;
    flag_check = 1'b0;
  endtask

  task automatic clear_inputs();
    clear_strobes();
    in_data      = '0;
    in_keep      = '0;
    in_last      = 1'b0;
    in_dest      = '0;
    slot_wr_ptr  = '0;
    slot_wr_addr = '0;
    msg_addr     = '0;
    msg_strb     = '0;
    msg_data     = '0;
    rd_addr      = '0;
    read_expect  = '0;
    flag_expect  = 1'b0;
  endtask

  // Hold the strobes for one clock, then drop them on the next falling edge
  task automatic end_cycle();
    @(negedge sys_clk);
    clear_strobes();
  endtask

  task automatic set_message(input logic [63:0] addr, strb, data);
    msg_valid = 1'b1;
    msg_addr  = addr_t'(addr);
    msg_strb  = msg_strb_t'(strb);
    msg_data  = msg_data_t'(data);
  endtask

  task automatic set_read(input logic [63:0] addr, expected);
    rd_req      = 1'b1;
    rd_addr     = addr_t'(addr);
    read_start  = 1'b1;
    read_expect = expected;
  endtask

  // Checker drops busy on rd_ack or on its own ack timeout
  task automatic wait_read_done();
    while (read_busy) begin
      @(negedge sys_clk);
    end
  endtask

  task automatic load_stimulus(output bit loaded);
    int    fd;
    string line;
    fd = $fopen(STIM_FILE, "r");
    loaded = (fd != 0);
    if (loaded) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          stim_lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Command decoder
  //////////////////////////////////////////////////
  task automatic run_line(input int line_num, input string line);
    byte         code;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] d;
    logic [63:0] e;
    int          n;
    bit          ok;
    code = (line.len() > 0) ? line[0] : "#";
    ok   = 1'b0;
    case (code)
      "B": begin
        n  = $sscanf(line, "B %h %h %h %h", a, b, c, d);
        ok = (n == 4);
        if (ok) begin
          in_valid = 1'b1;
          in_dest  = slot_id_t'(a);
          in_keep  = strb_t'(b);
          in_last  = c[0];
          in_data  = d;
          end_cycle();
        end
      end
      "S": begin
        n  = $sscanf(line, "S %h %h", a, b);
        ok = (n == 2);
        if (ok) begin
          slot_wr      = 1'b1;
          slot_wr_ptr  = a[SLOT_PTR_WIDTH-1:0];
          slot_wr_addr = addr_t'(b);
          end_cycle();
        end
      end
      "M": begin
        n  = $sscanf(line, "M %h %h %h", a, b, c);
        ok = (n == 3);
        if (ok) begin
          set_message(a, b, c);
          end_cycle();
        end
      end
      "R": begin
        n  = $sscanf(line, "R %h %h", a, b);
        ok = (n == 2);
        if (ok) begin
          set_read(a, b);
          end_cycle();
          wait_read_done();
        end
      end
      // Message and read in the same cycle, so the read has to wait
      "P": begin
        n  = $sscanf(line, "P %h %h %h %h %h", a, b, c, d, e);
        ok = (n == 5);
        if (ok) begin
          set_message(a, b, c);
          set_read(d, e);
          end_cycle();
          wait_read_done();
        end
      end
      "C": begin
        ok        = 1'b1;
        oob_clear = 1'b1;
        end_cycle();
      end
      "F": begin
        n  = $sscanf(line, "F %h", a);
        ok = (n == 1);
        if (ok) begin
          flag_check  = 1'b1;
          flag_expect = a[0];
          end_cycle();
        end
      end
      "I": begin
        n  = $sscanf(line, "I %d", a);
        ok = (n == 1);
        if (ok) begin
          repeat (int'(a)) @(negedge sys_clk);
        end
      end
      "#", "\n", "\r", " ": ok = 1'b1;
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      $display("Stimulus line %0d could not be understood", line_num);
      stim_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    bit loaded;
    int total;
    sys_rst = 1'b1;
    clear_inputs();
    load_stimulus(loaded);
    if (!loaded) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      $display("CHECKS FAILED");
      $finish;
    end else begin
      cycle_limit = CYCLES_PER_LINE * stim_lines.size() + CYCLE_MARGIN;
      repeat (RESET_CYCLES) @(negedge sys_clk);
      sys_rst = 1'b0;
      for (int i = 0; i < stim_lines.size(); i++) begin
        run_line(i + 1, stim_lines[i]);
      end
      // Let the checker settle its last compare
      repeat (2) @(negedge sys_clk);
      total = data_errors + flag_errors + ack_errors + stim_errors;
      $display("Errors: read data %0d, oob flag %0d, read ack %0d, stimulus %0d",
               data_errors, flag_errors, ack_errors, stim_errors);
      if (total == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/mem_checker.sv
/* Watches the DUT read port and out-of-bound flag and compares them with the
   values that tb_top hands over for each read or flag command */
`timescale 1ns/1ps
`default_nettype none

module mem_checker
  import riscv_mem_pkg::*;
(
  input  wire logic  sys_clk,
  input  wire logic  sys_rst,

  // DUT outputs under watch
  input  wire logic  rd_ack,
  input  wire line_t rd_data,
  input  wire logic  oob_flag,

  // Requests from the stimulus side
  input  wire logic  read_start,
  input  wire line_t read_expect,
  input  wire logic  flag_check,
  input  wire logic  flag_expect,

  output logic       read_busy,
  output int         data_errors,
  output int         flag_errors,
  output int         ack_errors
);

  localparam int ACK_WAIT_LIMIT = 8;

  line_t expect_line;
  int    wait_cycles;

  //////////////////////////////////////////////////
  // Read and flag compare
  //////////////////////////////////////////////////
  // Sampled on the rising edge, where DUT outputs still hold last cycle's value
  always @(posedge sys_clk) begin
    if (sys_rst) begin
      read_busy   <= 1'b0;
      wait_cycles <= 0;
      data_errors <= 0;
      flag_errors <= 0;
      ack_errors  <= 0;
    end else begin
      if (read_start) begin
        read_busy   <= 1'b1;
        expect_line <= read_expect;
        wait_cycles <= 0;
      end else if (read_busy) begin
        if (rd_ack) begin
          read_busy <= 1'b0;
          if (rd_data !== expect_line) begin
            $display("FAIL t=%0t rd_data expected %h got %h", $time, expect_line, rd_data);
            data_errors <= data_errors + 1;
          end
        end else if (wait_cycles == ACK_WAIT_LIMIT) begin
          $display("No rd_ack within %0d cycles of the read request, t=%0t",
                   ACK_WAIT_LIMIT, $time);
          ack_errors <= ack_errors + 1;
          read_busy  <= 1'b0;
        end else begin
          wait_cycles <= wait_cycles + 1;
        end
      end else if (rd_ack) begin
        $display("rd_ack came at t=%0t while no read was outstanding", $time);
        ack_errors <= ack_errors + 1;
      end

      if (flag_check && (oob_flag !== flag_expect)) begin
        $display("FAIL t=%0t oob_flag expected %0b got %0b", $time, flag_expect, oob_flag);
        flag_errors <= flag_errors + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/riscv_mem_top.sv
/* Memory-facing part of the core wrapper. Connects the slot table, the ingress
   writer, the message port arbiter and eight byte lanes of data memory */
`timescale 1ns/1ps
`default_nettype none

module riscv_mem_top
  import riscv_mem_pkg::*;
#(
  parameter int    SLOT_COUNT      = 8,
  parameter int    DMEM_SIZE_BYTES = 4096,
  parameter addr_t SLOT_START_ADDR = 16'h0200,
  parameter addr_t SLOT_ADDR_STEP  = 16'h0080,
  localparam int   SLOT_PTR_WIDTH  = $clog2(SLOT_COUNT),
  localparam int   LINE_AW         = $clog2(DMEM_SIZE_BYTES) - LINE_ADDR_BITS
) (
  input  wire logic                      sys_clk,
  input  wire logic                      sys_rst,

  // Ingress stream
  input  wire logic                      in_valid,
  input  wire line_t                     in_data,
  input  wire strb_t                     in_keep,
  input  wire logic                      in_last,
  input  wire slot_id_t                  in_dest,

  // Slot table write
  input  wire logic                      slot_wr,
  input  wire logic [SLOT_PTR_WIDTH-1:0] slot_wr_ptr,
  input  wire addr_t                     slot_wr_addr,

  // Core messages
  input  wire logic                      msg_valid,
  input  wire addr_t                     msg_addr,
  input  wire msg_strb_t                 msg_strb,
  input  wire msg_data_t                 msg_data,

  // Line read
  input  wire logic                      rd_req,
  input  wire addr_t                     rd_addr,
  output line_t                          rd_data,
  output logic                           rd_ack,

  // Out of bound flag
  input  wire logic                      oob_clear,
  output logic                           oob_flag
);

  logic [SLOT_PTR_WIDTH-1:0] lookup_ptr;
  addr_t                     lookup_addr;
  logic                      wr_en_a;
  logic [LINE_AW-1:0]        wr_addr_a;
  line_t                     wr_data_a;
  strb_t                     wr_mask_a;
  logic                      en_b;
  strb_t                     wen_b;
  logic [LINE_AW-1:0]        addr_b;
  line_t                     wdata_b;

  slot_addr_table #(
    .SLOT_COUNT      (SLOT_COUNT),
    .SLOT_START_ADDR (SLOT_START_ADDR),
    .SLOT_ADDR_STEP  (SLOT_ADDR_STEP)
  ) u_slot_table (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .slot_wr      (slot_wr),
    .slot_wr_ptr  (slot_wr_ptr),
    .slot_wr_addr (slot_wr_addr),
    .lookup_ptr   (lookup_ptr),
    .lookup_addr  (lookup_addr)
  );

  ingress_writer #(
    .SLOT_COUNT      (SLOT_COUNT),
    .DMEM_SIZE_BYTES (DMEM_SIZE_BYTES)
  ) u_ingress (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_keep     (in_keep),
    .in_last     (in_last),
    .in_dest     (in_dest),
    .lookup_ptr  (lookup_ptr),
    .lookup_addr (lookup_addr),
    .wr_en_a     (wr_en_a),
    .wr_addr_a   (wr_addr_a),
    .wr_data_a   (wr_data_a),
    .wr_mask_a   (wr_mask_a),
    .oob_clear   (oob_clear),
    .oob_flag    (oob_flag)
  );

  msg_port_arbiter #(
    .DMEM_SIZE_BYTES (DMEM_SIZE_BYTES)
  ) u_port_b (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .msg_valid (msg_valid),
    .msg_addr  (msg_addr),
    .msg_strb  (msg_strb),
    .msg_data  (msg_data),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_ack    (rd_ack),
    .en_b      (en_b),
    .wen_b     (wen_b),
    .addr_b    (addr_b),
    .wdata_b   (wdata_b)
  );

  //////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////
  for (genvar i = 0; i < STRB_WIDTH; i++) begin : g_lane
    dmem_byte_lane #(
      .DMEM_SIZE_BYTES (DMEM_SIZE_BYTES)
    ) u_lane (
      .sys_clk   (sys_clk),
      .wr_en_a   (wr_en_a & wr_mask_a[i]),
      .wr_addr_a (wr_addr_a),
      .wr_byte_a (wr_data_a[i*8 +: 8]),
      .en_b      (en_b),
      .wen_b     (wen_b[i]),
      .addr_b    (addr_b),
      .wdata_b   (wdata_b[i*8 +: 8]),
      .rdata_b   (rd_data[i*8 +: 8])
    );
  end

endmodule

`default_nettype wire

// File: src/dmem_byte_lane.sv
/* One byte column of the data memory. Port A only writes, port B either
   writes or does a registered read */
`timescale 1ns/1ps
`default_nettype none

module dmem_byte_lane
  import riscv_mem_pkg::*;
#(
  parameter int  DMEM_SIZE_BYTES = 4096,
  localparam int LINE_AW         = $clog2(DMEM_SIZE_BYTES) - LINE_ADDR_BITS,
  localparam int DEPTH           = DMEM_SIZE_BYTES / STRB_WIDTH
) (
  input  wire logic               sys_clk,

  input  wire logic               wr_en_a,
  input  wire logic [LINE_AW-1:0] wr_addr_a,
  input  wire logic [7:0]         wr_byte_a,

  input  wire logic               en_b,
  input  wire logic               wen_b,
  input  wire logic [LINE_AW-1:0] addr_b,
  input  wire logic [7:0]         wdata_b,
  output logic      [7:0]         rdata_b
);

  logic [7:0] mem [DEPTH];

  // Memory content starts cleared
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 8'h00;
    end
  end

  // Both ports share the clock, port B wins on a same-line write
  always_ff @(posedge sys_clk) begin
    if (wr_en_a) begin
      mem[wr_addr_a] <= wr_byte_a;
    end
    if (en_b) begin
      if (wen_b) begin
        mem[addr_b] <= wdata_b;
      end else begin
        rdata_b <= mem[addr_b];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/msg_port_arbiter.sv
/* Owner of memory port B. Registers broadcast core messages and writes them
   into the addressed half line, ahead of any waiting line read */
`timescale 1ns/1ps
`default_nettype none

module msg_port_arbiter
  import riscv_mem_pkg::*;
#(
  parameter int  DMEM_SIZE_BYTES = 4096,
  localparam int LINE_AW         = $clog2(DMEM_SIZE_BYTES) - LINE_ADDR_BITS
) (
  input  wire logic          sys_clk,
  input  wire logic          sys_rst,

  input  wire logic          msg_valid,
  input  wire addr_t         msg_addr,
  input  wire msg_strb_t     msg_strb,
  input  wire msg_data_t     msg_data,

  input  wire logic          rd_req,
  input  wire addr_t         rd_addr,
  output logic               rd_ack,

  output logic               en_b,
  output strb_t              wen_b,
  output logic [LINE_AW-1:0] addr_b,
  output line_t              wdata_b
);

  localparam int HALF_SEL = LINE_ADDR_BITS - 1;

  logic          msg_v_r;
  addr_t         msg_addr_r;
  msg_strb_t     msg_strb_r;
  msg_data_t     msg_data_r;
  strb_t         msg_mask;
  line_t         msg_line;
  port_b_state_t state;
  addr_t         rd_addr_r;
  logic          rd_issue;

  //////////////////////////////////////////////////
  // Message register
  //////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      msg_v_r <= 1'b0;
    end else begin
      msg_v_r <= msg_valid;
    end
    if (msg_valid) begin
      msg_addr_r <= msg_addr;
      msg_strb_r <= msg_strb;
      msg_data_r <= msg_data;
    end
  end

  // Upper 32 bits of the line when address bit 2 is set
  assign msg_mask = msg_addr_r[HALF_SEL] ? {msg_strb_r, {$bits(msg_strb_t){1'b0}}}
                                         : {{$bits(msg_strb_t){1'b0}}, msg_strb_r};
  assign msg_line = msg_addr_r[HALF_SEL] ? {msg_data_r, {$bits(msg_data_t){1'b0}}}
                                         : {{$bits(msg_data_t){1'b0}}, msg_data_r};

  //////////////////////////////////////////////////
  // Read FSM
  //////////////////////////////////////////////////
  // A read only goes out in a cycle with no message on the port
  assign rd_issue = (state == PB_READ_PENDING) && !msg_v_r;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state  <= PB_IDLE;
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd_issue;
      case (state)
        PB_IDLE: begin
          if (rd_req) begin
            state <= PB_READ_PENDING;
          end
        end
        PB_READ_PENDING: begin
          if (!msg_v_r) begin
            state <= PB_IDLE;
          end
        end
        default: state <= PB_IDLE;
      endcase
    end
    if (rd_req) begin
      rd_addr_r <= rd_addr;
    end
  end

  // Port B mux, message first
  assign en_b    = msg_v_r || rd_issue;
  assign wen_b   = msg_v_r ? msg_mask : '0;
  assign addr_b  = msg_v_r ? msg_addr_r[LINE_ADDR_BITS +: LINE_AW]
                           : rd_addr_r[LINE_ADDR_BITS +: LINE_AW];
  assign wdata_b = msg_line;

endmodule

`default_nettype wire

// File: src/ingress_writer.sv
/* Turns the incoming beat stream into port A line writes. Resolves the packet
   base from the slot table or a header beat and flags writes past the memory */
`timescale 1ns/1ps
`default_nettype none

module ingress_writer
  import riscv_mem_pkg::*;
#(
  parameter int  SLOT_COUNT      = 8,
  parameter int  DMEM_SIZE_BYTES = 4096,
  localparam int SLOT_PTR_WIDTH  = $clog2(SLOT_COUNT),
  localparam int LINE_AW         = $clog2(DMEM_SIZE_BYTES) - LINE_ADDR_BITS
) (
  input  wire logic                 sys_clk,
  input  wire logic                 sys_rst,

  input  wire logic                 in_valid,
  input  wire line_t                in_data,
  input  wire strb_t                in_keep,
  input  wire logic                 in_last,
  input  wire slot_id_t             in_dest,

  output logic [SLOT_PTR_WIDTH-1:0] lookup_ptr,
  input  wire addr_t                lookup_addr,

  output logic                      wr_en_a,
  output logic [LINE_AW-1:0]        wr_addr_a,
  output line_t                     wr_data_a,
  output strb_t                     wr_mask_a,

  input  wire logic                 oob_clear,
  output logic                      oob_flag
);

  // One spare bit so the line counter cannot wrap near the top of the space
  localparam int LINE_FULL_W = ADDR_WIDTH - LINE_ADDR_BITS + 1;
  localparam int DMEM_LINES  = DMEM_SIZE_BYTES >> LINE_ADDR_BITS;

  logic                      beat_valid;
  line_t                     beat_data;
  strb_t                     beat_keep;
  logic                      beat_first;
  logic                      beat_hdr_slot;
  logic [SLOT_PTR_WIDTH-1:0] beat_ptr;
  logic                      at_start;
  logic [LINE_FULL_W-1:0]    next_line;
  logic [LINE_FULL_W-1:0]    cur_line;
  logic                      is_header;
  logic                      beat_write;
  logic                      in_bound;
  slot_id_t                  dest_dec;

  assign dest_dec = in_dest - slot_id_t'(1);

  //////////////////////////////////////////////////
  // Beat register and packet start tracking
  //////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      beat_valid <= 1'b0;
      at_start   <= 1'b1;
    end else begin
      beat_valid <= in_valid;
      if (in_valid) begin
        at_start <= in_last;
      end
    end
    if (in_valid) begin
      beat_data     <= in_data;
      beat_keep     <= in_keep;
      beat_first    <= at_start;
      beat_hdr_slot <= (in_dest == '0);
      beat_ptr      <= dest_dec[SLOT_PTR_WIDTH-1:0];
    end
  end

  assign lookup_ptr = beat_ptr;
  assign is_header  = beat_first && beat_hdr_slot;

  // First data beat of a slot packet starts at the table base
  assign cur_line = beat_first ? {1'b0, lookup_addr[ADDR_WIDTH-1:LINE_ADDR_BITS]}
                               : next_line;

  always_ff @(posedge sys_clk) begin
    if (beat_valid) begin
      if (is_header) begin
        next_line <= {1'b0, beat_data[ADDR_WIDTH-1:LINE_ADDR_BITS]};
      end else begin
        next_line <= cur_line + LINE_FULL_W'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Port A drive and bound check
  //////////////////////////////////////////////////
  assign beat_write = beat_valid && !is_header;
  assign in_bound   = (cur_line < LINE_FULL_W'(DMEM_LINES));

  assign wr_en_a   = beat_write && in_bound;
  assign wr_addr_a = cur_line[LINE_AW-1:0];
  assign wr_data_a = beat_data;
  assign wr_mask_a = beat_keep;

  // Sticky until cleared, clear beats a new hit
  always_ff @(posedge sys_clk) begin
    if (sys_rst || oob_clear) begin
      oob_flag <= 1'b0;
    end else if (beat_write && !in_bound) begin
      oob_flag <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/slot_addr_table.sv
/* Per-slot base address table. Reset loads evenly spaced defaults, a write
   strobe replaces one entry, and the lookup is combinational */
`timescale 1ns/1ps
`default_nettype none

module slot_addr_table
  import riscv_mem_pkg::*;
#(
  parameter int    SLOT_COUNT      = 8,
  parameter addr_t SLOT_START_ADDR = 16'h0200,
  parameter addr_t SLOT_ADDR_STEP  = 16'h0080,
  localparam int   SLOT_PTR_WIDTH  = $clog2(SLOT_COUNT)
) (
  input  wire logic                      sys_clk,
  input  wire logic                      sys_rst,

  input  wire logic                      slot_wr,
  input  wire logic [SLOT_PTR_WIDTH-1:0] slot_wr_ptr,
  input  wire addr_t                     slot_wr_addr,

  input  wire logic [SLOT_PTR_WIDTH-1:0] lookup_ptr,
  output addr_t                          lookup_addr
);

  addr_t slot_base [SLOT_COUNT];

  //////////////////////////////////////////////////
  // Table update
  //////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slot_base[i] <= addr_t'(SLOT_START_ADDR + i * SLOT_ADDR_STEP);
      end
    end else if (slot_wr) begin
      slot_base[slot_wr_ptr] <= slot_wr_addr;
    end
  end

  // Read straight out of the registers so the writer sees it in the same cycle
  assign lookup_addr = slot_base[lookup_ptr];

endmodule

`default_nettype wire

// File: src/riscv_mem_pkg.sv
/* Widths, typedefs and the port B state encoding shared by the data memory
   RTL. Modules pull these in with a wildcard import in their header */
`default_nettype none

package riscv_mem_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  parameter int ADDR_WIDTH     = 16;
  parameter int DATA_WIDTH     = 64;
  parameter int STRB_WIDTH     = 8;
  parameter int LINE_ADDR_BITS = 3;

  //////////////////////////////////////////////////
  // Typedefs
  //////////////////////////////////////////////////
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] line_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;

  // Slot 0 means the packet starts with an address header
  typedef logic [3:0] slot_id_t;

  // Core message payload and byte mask
  typedef logic [31:0] msg_data_t;
  typedef logic [3:0]  msg_strb_t;

  // Port B arbiter states
  typedef enum logic {
    PB_IDLE,
    PB_READ_PENDING
  } port_b_state_t;

endpackage

`default_nettype wire
